// File: clock_comp/am_period_counter.sv
`timescale 1ns/1ps
`include "pcs_rx_cfg.svh"

// marker window watch and idle debt bookkeeping
module am_period_counter (
    input  logic                    i_clock,
    input  logic                    i_rst,
    input  logic                    i_advance,   // enable and valid
    input  logic                    i_am_tag,    // marker, deleted this slot
    input  logic                    i_inserted,  // idle added this slot
    output logic [2:0]              o_pending,
    output pcs_rx_pkg::cc_status_t  o_status
);

    localparam int         WINDOW   = `CC_AM_PERIOD * `CC_N_LANES;  // blocks per marker group
    localparam int         WIN_W    = $clog2(WINDOW + 2);           // room for window + 1
    localparam logic [2:0] PEND_MAX = 3'(`CC_N_LANES);

    logic [WIN_W-1:0] win_cnt;  // advances since last marker
    logic             am_lost;
    logic [2:0]       pending;
    logic             deleted;

    assign deleted = i_advance & i_am_tag;

    always_ff @(posedge i_clock)
    begin
        if (i_rst)
        begin
            win_cnt <= '0;
            am_lost <= 1'b0;
        end
        else if (deleted)
        begin
            win_cnt <= '0;    // restart window
            am_lost <= 1'b0;  // marker seen again
        end
        else if (i_advance)
        begin
            if (win_cnt <= WIN_W'(WINDOW))
                win_cnt <= win_cnt + 1'b1;  // stops at window + 1
            if (win_cnt >= WIN_W'(WINDOW))
                am_lost <= 1'b1;            // this slot passes the window
        end
    end

    // one up per deleted marker, one down per added idle
    always_ff @(posedge i_clock)
    begin
        if (i_rst)
            pending <= 3'd0;
        else if (deleted && !i_inserted && pending < PEND_MAX)
            pending <= pending + 3'd1;
        else if (i_inserted && !deleted && pending != 3'd0)
            pending <= pending - 3'd1;
    end

    assign o_pending        = pending;
    assign o_status.am_lost = am_lost;
    assign o_status.pending = pending;

endmodule

// File: clock_comp/cc_output_stage.sv
`timescale 1ns/1ps

// fifo head compare, idle substitution and output register
module cc_output_stage (
    input  logic                     i_clock,
    input  logic                     i_rst,
    input  logic                     i_advance,    // slot requested this cycle
    input  logic                     i_insert,     // slot is an added idle
    input  pcs_rx_pkg::pcs_block_t   i_fifo_data,  // registered fifo read data
    output logic                     o_head_idle,
    output pcs_rx_pkg::pcs_block_t   o_block,
    output logic                     o_valid
);

    logic                    adv_q;    // lines up with fifo read data
    logic                    ins_q;
    pcs_rx_pkg::pcs_block_t  blk_sel;

    // head is the last block read, the one an added idle would follow
    assign o_head_idle = (i_fifo_data == pcs_rx_pkg::PCS_IDLE);

    // on an insert slot the read was held, data is stale
    assign blk_sel = ins_q ? pcs_rx_pkg::PCS_IDLE : i_fifo_data;

    always_ff @(posedge i_clock)
    begin
        if (i_rst)
        begin
            adv_q   <= 1'b0;
            ins_q   <= 1'b0;
            o_valid <= 1'b0;
        end
        else
        begin
            adv_q   <= i_advance;
            ins_q   <= i_advance & i_insert;
            o_valid <= adv_q;  // two cycles after the slot
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (adv_q)
            o_block <= blk_sel;  // holds between valid slots
    end

endmodule

// File: clock_comp/clock_comp_rx.sv
`timescale 1ns/1ps

// rx clock compensation
// markers are dropped at the fifo write side, idles are
// added back at the read side next to an existing idle
module clock_comp_rx (
    input  logic                     i_clock,
    input  logic                     i_rst,
    input  logic                     i_enable,   // freeze when low
    input  logic                     i_valid,    // one block per cycle high
    input  logic                     i_am_tag,   // current block is a marker
    input  pcs_rx_pkg::pcs_block_t   i_block,
    output pcs_rx_pkg::pcs_block_t   o_block,
    output logic                     o_valid,
    output pcs_rx_pkg::cc_status_t   o_status
);

    logic                    advance;     // block slot this cycle
    logic [2:0]              pending;     // idle debt
    logic                    head_idle;   // fifo head is an idle
    logic                    insert_now;  // emit idle, hold read
    logic                    fifo_empty;
    logic                    fifo_full;
    pcs_rx_pkg::pcs_block_t  fifo_data;

    assign advance = i_enable & i_valid;

    // markers never enter, reads pause while inserting
    sync_fifo #(
        .payload_t    (pcs_rx_pkg::pcs_block_t),
        .PRELOAD_WORD (pcs_rx_pkg::PCS_IDLE)
    ) fifo_i (
        .i_clock (i_clock),
        .i_rst   (i_rst),
        .i_write (advance & ~i_am_tag),
        .i_read  (advance & ~insert_now),
        .i_data  (i_block),
        .o_data  (fifo_data),
        .o_empty (fifo_empty),
        .o_full  (fifo_full)
    );

    am_period_counter counter_i (
        .i_clock    (i_clock),
        .i_rst      (i_rst),
        .i_advance  (advance),
        .i_am_tag   (i_am_tag),
        .i_inserted (insert_now),
        .o_pending  (pending),
        .o_status   (o_status)
    );

    idle_insert_fsm fsm_i (
        .i_clock     (i_clock),
        .i_rst       (i_rst),
        .i_advance   (advance),
        .i_am_tag    (i_am_tag),
        .i_head_idle (head_idle),
        .i_pending   (pending),
        .o_insert    (insert_now)
    );

    cc_output_stage out_i (
        .i_clock     (i_clock),
        .i_rst       (i_rst),
        .i_advance   (advance),
        .i_insert    (insert_now),
        .i_fifo_data (fifo_data),
        .o_head_idle (head_idle),
        .o_block     (o_block),
        .o_valid     (o_valid)
    );

endmodule

// File: clock_comp/idle_insert_fsm.sv
`timescale 1ns/1ps

// decides when the deleted marker slots get paid back
// an idle is only added while the block at the fifo head is an idle,
// so the decoder sees a longer idle run and never a split sequence
module idle_insert_fsm (
    input  logic       i_clock,
    input  logic       i_rst,
    input  logic       i_advance,    // enable and valid
    input  logic       i_am_tag,     // marker on this slot
    input  logic       i_head_idle,  // from output stage compare
    input  logic [2:0] i_pending,    // idle debt from counter
    output logic       o_insert
);

    pcs_rx_pkg::cc_state_t state;
    pcs_rx_pkg::cc_state_t state_next;
    logic                  pending_nz;
    logic                  in_insert;

    assign pending_nz = (i_pending != 3'd0);
    assign in_insert  = (state == pcs_rx_pkg::INSERT);

    always_comb
    begin
        state_next = state;  // hold by default
        case (state)
            pcs_rx_pkg::PASS:
            begin
                // first marker of a group
                if (i_advance && i_am_tag)
                    state_next = pcs_rx_pkg::ARMED;
            end
            pcs_rx_pkg::ARMED:
            begin
                // more markers keep us waiting
                if (i_advance && i_head_idle && !i_am_tag)
                    state_next = pcs_rx_pkg::INSERT;
            end
            pcs_rx_pkg::INSERT:
            begin
                if (i_advance)
                begin
                    if (i_am_tag)
                        state_next = pcs_rx_pkg::ARMED;  // new marker, wait for next idle
                    else if (!pending_nz)
                        state_next = pcs_rx_pkg::PASS;   // debt repaid
                end
            end
            default:
                state_next = pcs_rx_pkg::PASS;
        endcase
    end

    always_ff @(posedge i_clock)
    begin
        if (i_rst)
            state <= pcs_rx_pkg::PASS;
        else
            state <= state_next;
    end

    // the read on the ARMED exit slot can move a data block to the head,
    // in that case keep reading until an idle shows up again
    // once inserting the read is held, so the idle stays at the head
    assign o_insert = i_advance & in_insert & pending_nz & i_head_idle;

endmodule

// File: common/pcs_rx_cfg.svh
`ifndef PCS_RX_CFG_SVH
`define PCS_RX_CFG_SVH

// lanes after reorder
// one marker per lane per group, so also the max idle debt
`define CC_N_LANES 4

// blocks per lane between markers
// short value for simulation, real PCS is far longer
`define CC_AM_PERIOD 64

// fifo address width, depth is 2**addr
`define CC_FIFO_ADDR 4

// occupancy right after reset
// enough slack to absorb a whole marker group plus one
`define CC_PRELOAD (`CC_N_LANES + 1)

`endif

// File: common/pcs_rx_pkg.sv
package pcs_rx_pkg;

    // 66-bit block as it comes out of the block lock / reorder path
    typedef struct packed {
        logic [1:0]  sync_hdr;  // 01 data, 10 control
        logic [63:0] payload;   // block type in top byte for control
    } pcs_block_t;

    localparam logic [1:0] SYNC_CTRL = 2'b10;  // control sync header
    localparam logic [7:0] BT_IDLE   = 8'h1e;  // all-idle block type

    // control block, type 1E, all control chars zero
    localparam pcs_block_t PCS_IDLE = '{
        sync_hdr: SYNC_CTRL,
        payload:  {BT_IDLE, 56'h0}
    };

    // insertion fsm states
    // PASS    nothing owed, fifo passes straight through
    // ARMED   markers deleted, waiting for an idle at the fifo head
    // INSERT  repaying idles, read held
    typedef enum logic [1:0] {
        PASS   = 2'd0,
        ARMED  = 2'd1,
        INSERT = 2'd2
    } cc_state_t;

    // status to the management side
    typedef struct packed {
        logic       am_lost;  // sticky until next marker
        logic [2:0] pending;  // deleted blocks not yet repaid
    } cc_status_t;

endpackage

// File: project.f
+incdir+common
common/pcs_rx_pkg.sv
rtl/sync_fifo.sv
clock_comp/am_period_counter.sv
clock_comp/idle_insert_fsm.sv
clock_comp/cc_output_stage.sv
clock_comp/clock_comp_rx.sv
test/clock_comp_properties.sv
test/clock_comp_checker.sv
test/tb_clock_comp.sv

// File: rtl/sync_fifo.sv
`timescale 1ns/1ps
`include "pcs_rx_cfg.svh"

// single clock fifo, registered read
// comes out of reset already holding PRELOAD words
module sync_fifo #(
    parameter type      payload_t    = pcs_rx_pkg::pcs_block_t,
    parameter payload_t PRELOAD_WORD = pcs_rx_pkg::PCS_IDLE  // fill value of preload slots
) (
    input  logic     i_clock,
    input  logic     i_rst,
    input  logic     i_write,
    input  logic     i_read,
    input  payload_t i_data,
    output payload_t o_data,
    output logic     o_empty,
    output logic     o_full
);

    localparam int ADDR_W  = `CC_FIFO_ADDR;
    localparam int DEPTH   = 1 << ADDR_W;
    localparam int PRELOAD = `CC_PRELOAD;

    payload_t          mem [DEPTH];
    payload_t          rd_data;
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W:0]   count;     // words stored, not yet read
    logic              do_write;
    logic              do_read;

    assign do_write = i_write & ~o_full;   // drop on overflow
    assign do_read  = i_read & ~o_empty;   // no pop on empty

    always_ff @(posedge i_clock)
    begin
        if (i_rst)
        begin
            rd_ptr <= '0;
            wr_ptr <= ADDR_W'(PRELOAD);        // preload slack
            count  <= (ADDR_W + 1)'(PRELOAD);
        end
        else
        begin
            if (do_write)
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            if (do_read)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    // slots below the reset write pointer get the fill word
    always_ff @(posedge i_clock)
    begin
        if (i_rst)
        begin
            for (int i = 0; i < PRELOAD; i++)
                mem[i] <= PRELOAD_WORD;
        end
        else if (do_write)
        begin
            mem[wr_ptr] <= i_data;
        end
    end

    // read data held while no read
    always_ff @(posedge i_clock)
    begin
        if (do_read)
            rd_data <= mem[rd_ptr];
    end

    assign o_data  = rd_data;
    assign o_empty = (count == '0);
    assign o_full  = (count == (ADDR_W + 1)'(DEPTH));

endmodule

// File: run_sim.sh
#!/bin/sh
# build the clock compensation testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_clock_comp \
    -f project.f -o sim_clock_comp

out=$(./obj_dir/sim_clock_comp +verilator+error+limit+1000 || true)
echo "$out"

if echo "$out" | grep -qx "=== PASS ==="; then
    exit 0
fi
echo "simulation did not report a pass"
exit 1

// File: test/clock_comp_checker.sv
`timescale 1ns/1ps
`include "pcs_rx_cfg.svh"

// reference model of the compensation stage, block streams and status only
module clock_comp_checker (
    input  logic                    i_clock,
    input  logic                    i_rst,
    input  logic                    i_enable,
    input  logic                    i_valid,
    input  logic                    i_am_tag,
    input  pcs_rx_pkg::pcs_block_t  i_block,
    input  pcs_rx_pkg::pcs_block_t  i_out_block,
    input  logic                    i_out_valid,
    input  pcs_rx_pkg::cc_status_t  i_status,
    input  logic                    i_end_check,   // stimulus done, pipeline drained
    output int                      o_stream_errors,
    output int                      o_latency_errors,
    output int                      o_status_errors,
    output logic                    o_end_done
);

    localparam int WINDOW = `CC_AM_PERIOD * `CC_N_LANES;

    pcs_rx_pkg::pcs_block_t exp_data[$];  // untagged data blocks, arrival order
    int   exp_run[$];                     // input idles right before each one
    int   in_run;       // idles since last input data block
    int   out_run;      // idles since last output data block
    int   in_idles;
    int   out_idles;
    int   deleted;      // tagged blocks seen
    int   win_cnt;      // untagged advances since last tag
    int   lost_rises;
    logic exp_lost;
    logic adv_d1;
    logic adv_d2;

    task reset_model();
        exp_data.delete();
        exp_run.delete();
        in_run     = `CC_PRELOAD;  // preload idles lead the stream
        out_run    = 0;
        in_idles   = 0;
        out_idles  = 0;
        deleted    = 0;
        win_cnt    = 0;
        lost_rises = 0;
        exp_lost   = 1'b0;
        adv_d1     = 1'b0;
        adv_d2     = 1'b0;
        o_end_done = 1'b0;
    endtask

    task record_input(input pcs_rx_pkg::pcs_block_t blk, input logic tag);
        if (tag)
        begin
            deleted++;
            win_cnt  = 0;      // marker restarts the window
            exp_lost = 1'b0;
        end
        else
        begin
            if (win_cnt <= WINDOW)
                win_cnt++;
            if (win_cnt > WINDOW && !exp_lost)
            begin
                exp_lost = 1'b1;
                lost_rises++;
            end
            if (blk === pcs_rx_pkg::PCS_IDLE)
            begin
                in_run++;
                in_idles++;
            end
            else
            begin
                exp_data.push_back(blk);
                exp_run.push_back(in_run);
                in_run = 0;
            end
        end
    endtask

    task check_output(input pcs_rx_pkg::pcs_block_t blk);
        pcs_rx_pkg::pcs_block_t exp;
        int run;
        if (blk === pcs_rx_pkg::PCS_IDLE)
        begin
            out_run++;
            out_idles++;
        end
        else if (exp_data.size() == 0)
        begin
            $display("ERR %0t: data block %h out, none expected", $time, blk);
            o_stream_errors++;
        end
        else
        begin
            exp = exp_data.pop_front();
            run = exp_run.pop_front();
            if (blk !== exp)
            begin
                $display("ERR %0t: data block %h, expected %h", $time, blk, exp);
                o_stream_errors++;
            end
            // added idles may only lengthen a run that already has an idle
            if (out_run < run || (out_run > run && run == 0))
            begin
                $display("ERR %0t: idle run of %0d before %h, input run %0d",
                         $time, out_run, blk, run);
                o_stream_errors++;
            end
        end
        if (blk !== pcs_rx_pkg::PCS_IDLE)
            out_run = 0;
    endtask

    task final_checks();
        if (exp_data.size() != 0)
        begin
            $display("ERR %0t: %0d data blocks never came out", $time, exp_data.size());
            o_stream_errors++;
        end
        // the same number of flush idles stay behind in the fifo
        if (out_idles != in_idles + deleted)
        begin
            $display("ERR %0t: %0d idles out, expected %0d", $time, out_idles,
                     in_idles + deleted);
            o_stream_errors++;
        end
        if (i_status.pending != 3'd0)
        begin
            $display("ERR %0t: pending %0d after flush, expected 0", $time,
                     i_status.pending);
            o_status_errors++;
        end
        if (deleted == 0 || lost_rises == 0)
        begin
            $display("marker groups or marker loss were never exercised");
            o_status_errors++;
        end
        o_end_done = 1'b1;
    endtask

    initial
    begin
        o_stream_errors  = 0;
        o_latency_errors = 0;
        o_status_errors  = 0;
        reset_model();
    end

    always @(posedge i_clock)
    begin
        logic adv;
        adv = i_enable & i_valid;
        if (i_rst)
            reset_model();
        else
        begin
            if (i_out_valid !== adv_d2)  // slot two edges back
            begin
                $display("ERR %0t: o_valid %b, expected %b", $time, i_out_valid, adv_d2);
                o_latency_errors++;
            end
            adv_d2 = adv_d1;
            adv_d1 = adv;
            if (i_status.am_lost !== exp_lost)
            begin
                $display("ERR %0t: am_lost %b, expected %b", $time, i_status.am_lost,
                         exp_lost);
                o_status_errors++;
            end
            if (i_out_valid)
                check_output(i_out_block);
            if (adv)
                record_input(i_block, i_am_tag);
            if (i_end_check && !o_end_done)
                final_checks();
        end
    end

endmodule

// File: test/clock_comp_properties.sv
`timescale 1ns/1ps
`include "pcs_rx_cfg.svh"

// protocol checks inside the clock compensation top
module clock_comp_properties (
    input logic                   i_clock,
    input logic                   i_rst,
    input logic                   i_advance,
    input logic                   i_am_tag,
    input logic                   i_insert,
    input logic                   i_fifo_empty,
    input logic                   i_fifo_full,
    input logic [2:0]             i_pending,
    input pcs_rx_pkg::cc_state_t  i_state,
    input logic                   i_out_valid
);

    int fail_count = 0;  // assertion failures so far

    // every slot that is not an added idle pops the fifo
    read_not_empty: assert property (@(posedge i_clock) disable iff (i_rst)
        (i_advance && !i_insert) |-> !i_fifo_empty)
    else
    begin
        $error("fifo read while empty");
        fail_count++;
    end

    write_not_full: assert property (@(posedge i_clock) disable iff (i_rst)
        (i_advance && !i_am_tag) |-> !i_fifo_full)  // markers never written
    else
    begin
        $error("fifo write while full");
        fail_count++;
    end

    // debt is bounded by one marker group
    // a marker dropped at full debt would never be paid back
    debt_not_saturated: assert property (@(posedge i_clock) disable iff (i_rst)
        (i_advance && i_am_tag && !i_insert) |-> (i_pending < 3'(`CC_N_LANES)))
    else
    begin
        $error("marker deleted with idle debt already at lane count");
        fail_count++;
    end

    // fsm only goes idle once the counter shows nothing owed
    pass_owes_nothing: assert property (@(posedge i_clock) disable iff (i_rst)
        (i_state == pcs_rx_pkg::PASS) |-> (i_pending == 3'd0))
    else
    begin
        $error("fsm in PASS state while idles are still owed");
        fail_count++;
    end

    valid_low_after_reset: assert property (@(posedge i_clock)
        i_rst |=> !i_out_valid)
    else
    begin
        $error("output valid high right after reset");
        fail_count++;
    end

endmodule

bind clock_comp_rx clock_comp_properties props_i (
    .i_clock      (i_clock),
    .i_rst        (i_rst),
    .i_advance    (advance),
    .i_am_tag     (i_am_tag),
    .i_insert     (insert_now),
    .i_fifo_empty (fifo_empty),
    .i_fifo_full  (fifo_full),
    .i_pending    (pending),
    .i_state      (fsm_i.state),
    .i_out_valid  (o_valid)
);

// File: test/tb_clock_comp.sv
`timescale 1ns/1ps
`include "pcs_rx_cfg.svh"

module tb_clock_comp;

    localparam int WINDOW     = `CC_AM_PERIOD * `CC_N_LANES;
    localparam int P1_PERIODS = 4;
    localparam int P2_PERIODS = 2;
    localparam int LOSS_EXTRA = 40;                     // tag gap past the window
    localparam int FLUSH_LEN  = 2 * (1 << `CC_FIFO_ADDR);
    localparam int RST_CYCLES = 16;
    localparam int SLOT_MAX   = 12;                     // gap plus enable low per block
    localparam int N_SLOTS    = (P1_PERIODS + P2_PERIODS + 1) * WINDOW + LOSS_EXTRA
                              + `CC_N_LANES + FLUSH_LEN;
    localparam int WATCHDOG_CYCLES = 2 * (RST_CYCLES + N_SLOTS * SLOT_MAX);
    localparam logic [63:0] AM_BASE = 64'h9076_4700_6f89_b800;  // marker payload

    logic                    clock;
    logic                    rst;
    logic                    enable;
    logic                    valid;
    logic                    am_tag;
    logic                    end_check;
    logic                    end_done;
    logic                    out_valid;
    pcs_rx_pkg::pcs_block_t  in_block;
    pcs_rx_pkg::pcs_block_t  out_block;
    pcs_rx_pkg::cc_status_t  status;
    int                      stream_errs;
    int                      latency_errs;
    int                      status_errs;
    int                      total_errs;
    int                      seed;
    int                      en_hold;  // enable low cycles left

    clock_comp_rx dut_i (
        .i_clock  (clock),
        .i_rst    (rst),
        .i_enable (enable),
        .i_valid  (valid),
        .i_am_tag (am_tag),
        .i_block  (in_block),
        .o_block  (out_block),
        .o_valid  (out_valid),
        .o_status (status)
    );

    clock_comp_checker chk_i (
        .i_clock          (clock),
        .i_rst            (rst),
        .i_enable         (enable),
        .i_valid          (valid),
        .i_am_tag         (am_tag),
        .i_block          (in_block),
        .i_out_block      (out_block),
        .i_out_valid      (out_valid),
        .i_status         (status),
        .i_end_check      (end_check),
        .o_stream_errors  (stream_errs),
        .o_latency_errors (latency_errs),
        .o_status_errors  (status_errs),
        .o_end_done       (end_done)
    );

    initial
    begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // about 30 percent idles, rest data
    function automatic pcs_rx_pkg::pcs_block_t random_block();
        pcs_rx_pkg::pcs_block_t blk;
        blk = pcs_rx_pkg::PCS_IDLE;
        if ($unsigned($random(seed)) % 10 >= 3)
        begin
            blk.sync_hdr = 2'b01;
            blk.payload  = {$random(seed), $random(seed)};
        end
        return blk;
    endfunction

    task next_enable(output logic en);
        if (en_hold > 0)
        begin
            en_hold--;
            en = 1'b0;
        end
        else if ($unsigned($random(seed)) % 64 == 0)
        begin
            en_hold = $unsigned($random(seed)) % 6;  // start a freeze window
            en      = 1'b0;
        end
        else
            en = 1'b1;
        enable <= en;
    endtask

    // random valid gap, then hold the block until it is taken
    task drive_slot(input pcs_rx_pkg::pcs_block_t blk, input logic tag);
        int   gap;
        logic en;
        gap = $unsigned($random(seed)) % 4;
        repeat (gap)
        begin
            @(posedge clock);
            valid  <= 1'b0;
            am_tag <= 1'b0;
            next_enable(en);
        end
        en = 1'b0;
        while (!en)
        begin
            @(posedge clock);
            valid    <= 1'b1;
            in_block <= blk;
            am_tag   <= tag;
            next_enable(en);
        end
    endtask

    task send_group();
        for (int lane = 0; lane < `CC_N_LANES; lane++)
            drive_slot({2'b10, AM_BASE ^ 64'(lane)}, 1'b1);
    endtask

    task send_period();
        repeat (WINDOW - `CC_N_LANES)
            drive_slot(random_block(), 1'b0);
        send_group();
    endtask

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    initial
    begin
        seed      = 78813;
        en_hold   = 0;
        rst       = 1'b1;
        enable    = 1'b0;
        valid     = 1'b0;
        am_tag    = 1'b0;
        in_block  = pcs_rx_pkg::PCS_IDLE;
        end_check = 1'b0;
        repeat (RST_CYCLES) @(posedge clock);
        rst <= 1'b0;
        repeat (P1_PERIODS) send_period();       // regular marker groups
        repeat (WINDOW + LOSS_EXTRA)             // tags stop past the window
            drive_slot(random_block(), 1'b0);
        send_group();
        repeat (P2_PERIODS) send_period();
        repeat (FLUSH_LEN)
            drive_slot(pcs_rx_pkg::PCS_IDLE, 1'b0);
        @(posedge clock);
        valid  <= 1'b0;
        am_tag <= 1'b0;
        repeat (4) @(posedge clock);             // two cycle pipeline drains
        end_check <= 1'b1;
        wait (end_done);
        total_errs = stream_errs + latency_errs + status_errs + dut_i.props_i.fail_count;
        $display("errors: stream %0d, latency %0d, status %0d, assertions %0d",
                 stream_errs, latency_errs, status_errs, dut_i.props_i.fail_count);
        if (total_errs == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule
